/* compile.f */
dmem_pkg.sv
sdp_ram.sv
store_align.sv
load_extract.sv
dmem_ctrl.sv
dmem_top.sv
dmem_chk.sv
dmem_tb.sv

/* dmem_chk.sv */
`timescale 1ns/10ps

module dmem_chk (
	input logic       clk,
	input logic       rst_n,
	input logic       req,
	input logic       we,
	input logic [1:0] size,
	input logic [1:0] offset,
	input logic       en,
	input logic       load_valid,
	input logic       err
);

	logic bad_align;

	// Refused sizes and offsets.
	assign bad_align = (size == dmem_pkg::SIZE_HALF && offset[0]) ||
		(size == dmem_pkg::SIZE_WORD && offset != 2'd0) || size == 2'd3;

	a_pulses_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(load_valid && err))
		else $error("load_valid and err are high in the same cycle");

	a_no_write_misaligned: assert property (@(posedge clk) disable iff (!rst_n)
		(req && bad_align) |-> !en)
		else $error("RAM write enabled for a misaligned request");

	a_load_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(req && !we && !bad_align) |-> ##2 load_valid)
		else $error("load_valid missing two cycles after an aligned load");

endmodule

bind dmem_ctrl dmem_chk dmem_chk_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.req        (req),
	.we         (we),
	.size       (size),
	.offset     (offset),
	.en         (en),
	.load_valid (load_valid),
	.err        (err)
);

/* dmem_ctrl.sv */
`timescale 1ns/10ps

module dmem_ctrl (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           req,
	input  logic                           we,
	input  logic [1:0]                     size,
	input  logic                           sign_ext,
	input  logic [1:0]                     offset,
	input  logic [dmem_pkg::WORD_BITS-1:0] extracted,
	output logic                           en,
	output logic [1:0]                     tag_offset,
	output logic [1:0]                     tag_size,
	output logic                           tag_sign,
	output logic                           load_valid,
	output logic [dmem_pkg::WORD_BITS-1:0] load_data,
	output logic                           err
);

	logic misaligned;
	logic load_req;
	logic tag_valid;

	// Alignment check against the access size.
	always_comb begin
		case (size)
			dmem_pkg::SIZE_BYTE: misaligned = 1'b0;
			dmem_pkg::SIZE_HALF: misaligned = offset[0];
			dmem_pkg::SIZE_WORD: misaligned = |offset;
			default:             misaligned = 1'b1;
		endcase
	end

	assign en = req & we & ~misaligned;
	assign load_req = req & ~we & ~misaligned;

	// Pipeline control.
	// Tag stage lines up with the RAM read, output stage one cycle later.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tag_valid <= 1'b0;
			load_valid <= 1'b0;
			err <= 1'b0;
		end else begin
			tag_valid <= load_req;
			load_valid <= tag_valid;
			err <= req & misaligned;
		end
	end

	// Tag fields for the load now reading the RAM.
	always_ff @(posedge clk) begin
		if (load_req) begin
			tag_offset <= offset;
			tag_size <= size;
			tag_sign <= sign_ext;
		end
	end

	always_ff @(posedge clk) begin
		if (tag_valid) begin
			load_data <= extracted;
		end
	end

endmodule

/* dmem_pkg.sv */
package dmem_pkg;

	// Byte address covers 1 KiB.
	localparam int ADDR_BITS = 10;
	localparam int WORD_ADDR_BITS = ADDR_BITS - 2;

	localparam int WORD_BITS = 32;
	localparam int LANE_BITS = 8;
	localparam int LANES = WORD_BITS / LANE_BITS;

	// Access size codes.
	// Code 3 is reserved and always refused.
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [LANES-1:0][LANE_BITS-1:0] lanes_t;

	// One memory word.
	// Seen either whole or as byte lanes, lane 0 being the low byte.
	typedef union packed {
		word_t  word;
		lanes_t lanes;
	} word_view_t;

endpackage

/* dmem_tb.sv */
`timescale 1ns/10ps

module dmem_tb;

	localparam int WAIT_LIMIT = 8;
	localparam int RANDOM_REQS = 400;

	logic                           clk;
	logic                           rst_n;
	logic                           req;
	logic                           we;
	logic [1:0]                     size;
	logic                           sign_ext;
	logic [dmem_pkg::ADDR_BITS-1:0] addr;
	logic [dmem_pkg::WORD_BITS-1:0] wdata;
	logic                           load_valid;
	logic [dmem_pkg::WORD_BITS-1:0] load_data;
	logic                           err;

	// Directed table, one entry per request.
	logic                           t_we [$];
	logic [1:0]                     t_size [$];
	logic                           t_sign [$];
	logic [dmem_pkg::ADDR_BITS-1:0] t_addr [$];
	logic [dmem_pkg::WORD_BITS-1:0] t_wdata [$];
	logic [dmem_pkg::WORD_BITS-1:0] t_data [$];
	logic                           t_err [$];

	// Reference memory and pending pulses of the random phase.
	logic [dmem_pkg::LANE_BITS-1:0] ref_mem [2**dmem_pkg::ADDR_BITS];
	int                             load_due [$];
	logic [dmem_pkg::WORD_BITS-1:0] load_exp [$];
	int                             err_due [$];
	logic [31:0]                    rng;

	dmem_top dmem_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.we         (we),
		.size       (size),
		.sign_ext   (sign_ext),
		.addr       (addr),
		.wdata      (wdata),
		.load_valid (load_valid),
		.load_data  (load_data),
		.err        (err)
	);

	always #20 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_load(input logic [dmem_pkg::WORD_BITS-1:0] got,
		input logic [dmem_pkg::WORD_BITS-1:0] exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("Fail at %0t ns: %s returned %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_err(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("Fail at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic is_misaligned(input logic [1:0] s,
		input logic [dmem_pkg::ADDR_BITS-1:0] a);
		case (s)
			dmem_pkg::SIZE_BYTE: return 1'b0;
			dmem_pkg::SIZE_HALF: return a[0];
			dmem_pkg::SIZE_WORD: return a[1:0] != 2'd0;
			default:             return 1'b1;
		endcase
	endfunction

	task automatic ref_store(input logic [1:0] s, input logic [dmem_pkg::ADDR_BITS-1:0] a,
		input logic [dmem_pkg::WORD_BITS-1:0] d);
		ref_mem[a] = d[7:0];
		if (s != dmem_pkg::SIZE_BYTE) begin
			ref_mem[a + 1'b1] = d[15:8];
		end
		if (s == dmem_pkg::SIZE_WORD) begin
			ref_mem[a + 2'd2] = d[23:16];
			ref_mem[a + 2'd3] = d[31:24];
		end
	endtask

	function automatic logic [31:0] ref_load(input logic [1:0] s, input logic sg,
		input logic [dmem_pkg::ADDR_BITS-1:0] a);
		logic [7:0] b0;
		logic [7:0] b1;
		b0 = ref_mem[a];
		b1 = ref_mem[a + 1'b1];
		case (s)
			dmem_pkg::SIZE_BYTE: return {{24{sg & b0[7]}}, b0};
			dmem_pkg::SIZE_HALF: return {{16{sg & b1[7]}}, b1, b0};
			default:             return {ref_mem[a + 2'd3], ref_mem[a + 2'd2], b1, b0};
		endcase
	endfunction

	task automatic add_store(input logic [1:0] s, input logic [dmem_pkg::ADDR_BITS-1:0] a,
		input logic [31:0] d, input logic e);
		t_we.push_back(1'b1);
		t_size.push_back(s);
		t_sign.push_back(1'b0);
		t_addr.push_back(a);
		t_wdata.push_back(d);
		t_data.push_back(32'h0);
		t_err.push_back(e);
	endtask

	task automatic add_load(input logic [1:0] s, input logic sg,
		input logic [dmem_pkg::ADDR_BITS-1:0] a, input logic [31:0] d, input logic e);
		t_we.push_back(1'b0);
		t_size.push_back(s);
		t_sign.push_back(sg);
		t_addr.push_back(a);
		t_wdata.push_back(32'h0);
		t_data.push_back(d);
		t_err.push_back(e);
	endtask

	task automatic build_table();
		// Word store, then a load in the very next cycle.
		add_store(dmem_pkg::SIZE_WORD, 10'h100, 32'hdeadbeef, 1'b0);
		add_load(dmem_pkg::SIZE_WORD, 1'b0, 10'h100, 32'hdeadbeef, 1'b0);
		// Narrow stores leave the other lanes alone.
		add_store(dmem_pkg::SIZE_WORD, 10'h104, 32'h11223344, 1'b0);
		add_store(dmem_pkg::SIZE_BYTE, 10'h105, 32'h000000aa, 1'b0);
		add_load(dmem_pkg::SIZE_WORD, 1'b0, 10'h104, 32'h1122aa44, 1'b0);
		add_store(dmem_pkg::SIZE_HALF, 10'h106, 32'h00005566, 1'b0);
		add_store(dmem_pkg::SIZE_HALF, 10'h104, 32'hffff9988, 1'b0);
		add_load(dmem_pkg::SIZE_WORD, 1'b0, 10'h104, 32'h55669988, 1'b0);
		add_store(dmem_pkg::SIZE_BYTE, 10'h107, 32'h123456c3, 1'b0);
		add_load(dmem_pkg::SIZE_WORD, 1'b0, 10'h104, 32'hc3669988, 1'b0);
		// Zero and sign extension at each legal offset.
		add_store(dmem_pkg::SIZE_WORD, 10'h108, 32'h80ff7f01, 1'b0);
		add_load(dmem_pkg::SIZE_BYTE, 1'b0, 10'h108, 32'h00000001, 1'b0);
		add_load(dmem_pkg::SIZE_BYTE, 1'b1, 10'h108, 32'h00000001, 1'b0);
		add_load(dmem_pkg::SIZE_BYTE, 1'b0, 10'h109, 32'h0000007f, 1'b0);
		add_load(dmem_pkg::SIZE_BYTE, 1'b1, 10'h109, 32'h0000007f, 1'b0);
		add_load(dmem_pkg::SIZE_BYTE, 1'b0, 10'h10a, 32'h000000ff, 1'b0);
		add_load(dmem_pkg::SIZE_BYTE, 1'b1, 10'h10a, 32'hffffffff, 1'b0);
		add_load(dmem_pkg::SIZE_BYTE, 1'b0, 10'h10b, 32'h00000080, 1'b0);
		add_load(dmem_pkg::SIZE_BYTE, 1'b1, 10'h10b, 32'hffffff80, 1'b0);
		add_load(dmem_pkg::SIZE_HALF, 1'b0, 10'h108, 32'h00007f01, 1'b0);
		add_load(dmem_pkg::SIZE_HALF, 1'b1, 10'h108, 32'h00007f01, 1'b0);
		add_load(dmem_pkg::SIZE_HALF, 1'b0, 10'h10a, 32'h000080ff, 1'b0);
		add_load(dmem_pkg::SIZE_HALF, 1'b1, 10'h10a, 32'hffff80ff, 1'b0);
		// Refused requests, then the word they aimed at.
		add_store(dmem_pkg::SIZE_HALF, 10'h101, 32'h00001234, 1'b1);
		add_store(dmem_pkg::SIZE_WORD, 10'h102, 32'h12345678, 1'b1);
		add_store(2'd3, 10'h100, 32'h00000000, 1'b1);
		add_load(dmem_pkg::SIZE_WORD, 1'b0, 10'h10a, 32'h0, 1'b1);
		add_load(dmem_pkg::SIZE_HALF, 1'b1, 10'h10b, 32'h0, 1'b1);
		add_load(dmem_pkg::SIZE_WORD, 1'b0, 10'h100, 32'hdeadbeef, 1'b0);
	endtask

	task automatic wait_for_load(input int idx);
		int waited;
		waited = 0;
		@(negedge clk);
		while (load_valid !== 1'b1) begin
			if (waited == WAIT_LIMIT) begin
				report_failure($sformatf("Timeout: no load_valid for table entry %0d", idx));
			end
			waited++;
			@(negedge clk);
		end
		check_err(err, 1'b0, $sformatf("err with load of entry %0d", idx));
		check_load(load_data, t_data[idx], $sformatf("table entry %0d", idx));
	endtask

	task automatic wait_for_err(input int idx);
		int waited;
		waited = 0;
		@(negedge clk);
		while (err !== 1'b1) begin
			if (waited == WAIT_LIMIT) begin
				report_failure($sformatf("Timeout: no err pulse for table entry %0d", idx));
			end
			waited++;
			@(negedge clk);
		end
		repeat (3) begin
			check_err(load_valid, 1'b0, $sformatf("load_valid after entry %0d", idx));
			@(negedge clk);
		end
	endtask

	task automatic run_directed();
		for (int i = 0; i < t_we.size(); i++) begin
			@(posedge clk);
			req <= 1'b1;
			we <= t_we[i];
			size <= t_size[i];
			sign_ext <= t_sign[i];
			addr <= t_addr[i];
			wdata <= t_wdata[i];
			if (t_we[i] && !is_misaligned(t_size[i], t_addr[i])) begin
				ref_store(t_size[i], t_addr[i], t_wdata[i]);
			end
			// Aligned stores run back to back.
			if (!t_we[i] || t_err[i]) begin
				@(posedge clk);
				req <= 1'b0;
				if (t_err[i]) begin
					wait_for_err(i);
				end else begin
					wait_for_load(i);
				end
			end
		end
		@(posedge clk);
		req <= 1'b0;
	endtask

	task automatic check_cycle(input int cyc);
		logic expect_load;
		logic expect_err;
		expect_load = load_due.size() > 0 && load_due[0] == cyc;
		expect_err = err_due.size() > 0 && err_due[0] == cyc;
		if (expect_load && load_valid !== 1'b1) begin
			report_failure($sformatf("No load_valid at %0t ns two cycles after a load", $time));
		end
		if (expect_err && err !== 1'b1) begin
			report_failure($sformatf("No err pulse at %0t ns after a refused request", $time));
		end
		check_err(load_valid, expect_load, "load_valid");
		check_err(err, expect_err, "err");
		if (expect_load) begin
			check_load(load_data, load_exp.pop_front(), "random load");
			void'(load_due.pop_front());
		end
		if (expect_err) begin
			void'(err_due.pop_front());
		end
	endtask

	task automatic run_random();
		logic [31:0]                    r;
		logic                           r_req;
		logic                           r_we;
		logic                           r_sign;
		logic [1:0]                     r_size;
		logic [dmem_pkg::ADDR_BITS-1:0] r_addr;
		logic [31:0]                    r_wdata;
		logic                           prev_load;
		int                             cyc;
		prev_load = 1'b0;
		cyc = 0;
		for (int n = 0; n < RANDOM_REQS + 4; n++) begin
			@(posedge clk);
			cyc++;
			rng = xorshift(rng);
			r = rng;
			rng = xorshift(rng);
			r_wdata = rng;
			r_req = n < RANDOM_REQS && r[18:16] != 3'd0;
			r_we = r[0];
			r_sign = r[15];
			r_size = r[2:1];
			if (r_size == 2'd3 && r[3]) begin
				r_size = dmem_pkg::SIZE_WORD;
			end
			r_addr = r[13:4];
			if (r[14] && r_size == dmem_pkg::SIZE_HALF) begin
				r_addr[0] = 1'b0;
			end else if (r[14] && r_size == dmem_pkg::SIZE_WORD) begin
				r_addr[1:0] = 2'd0;
			end
			// A refusal right after a load would pulse err with that load's load_valid.
			if (prev_load && is_misaligned(r_size, r_addr)) begin
				r_size = dmem_pkg::SIZE_BYTE;
			end
			req <= r_req;
			we <= r_we;
			size <= r_size;
			sign_ext <= r_sign;
			addr <= r_addr;
			wdata <= r_wdata;
			prev_load = r_req && !r_we && !is_misaligned(r_size, r_addr);
			if (r_req && is_misaligned(r_size, r_addr)) begin
				err_due.push_back(cyc + 1);
			end else if (r_req && r_we) begin
				ref_store(r_size, r_addr, r_wdata);
			end else if (r_req) begin
				load_due.push_back(cyc + 2);
				load_exp.push_back(ref_load(r_size, r_sign, r_addr));
			end
			@(negedge clk);
			check_cycle(cyc);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req = 1'b0;
		we = 1'b0;
		size = 2'd0;
		sign_ext = 1'b0;
		addr = '0;
		wdata = '0;
		rng = 32'd2;
		for (int i = 0; i < 2**dmem_pkg::ADDR_BITS; i++) begin
			ref_mem[i] = 8'h00;
		end
		build_table();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		run_directed();
		run_random();
		if (load_due.size() != 0 || err_due.size() != 0) begin
			report_failure("Some expected load_valid or err pulses never arrived");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

/* dmem_top.sv */
`timescale 1ns/10ps

module dmem_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           req,
	input  logic                           we,
	input  logic [1:0]                     size,
	input  logic                           sign_ext,
	input  logic [dmem_pkg::ADDR_BITS-1:0] addr,
	input  logic [dmem_pkg::WORD_BITS-1:0] wdata,
	output logic                           load_valid,
	output logic [dmem_pkg::WORD_BITS-1:0] load_data,
	output logic                           err
);

	logic                                en;
	logic [dmem_pkg::LANES-1:0]          strobe;
	logic [dmem_pkg::WORD_ADDR_BITS-1:0] word_addr;
	dmem_pkg::word_view_t                wr_word;
	dmem_pkg::word_view_t                rd_word;
	logic [1:0]                          tag_offset;
	logic [1:0]                          tag_size;
	logic                                tag_sign;
	logic [dmem_pkg::WORD_BITS-1:0]      extracted;

	assign word_addr = addr[dmem_pkg::ADDR_BITS-1:2];

	dmem_ctrl dmem_ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.we         (we),
		.size       (size),
		.sign_ext   (sign_ext),
		.offset     (addr[1:0]),
		.extracted  (extracted),
		.en         (en),
		.tag_offset (tag_offset),
		.tag_size   (tag_size),
		.tag_sign   (tag_sign),
		.load_valid (load_valid),
		.load_data  (load_data),
		.err        (err)
	);

	store_align store_align_i (
		.size   (size),
		.offset (addr[1:0]),
		.wdata  (wdata),
		.strobe (strobe),
		.lanes  (wr_word)
	);

	// Both ports use the same word address.
	sdp_ram sdp_ram_i (
		.clk    (clk),
		.en     (en),
		.waddr  (word_addr),
		.raddr  (word_addr),
		.strobe (strobe),
		.wdata  (wr_word),
		.rdata  (rd_word)
	);

	load_extract load_extract_i (
		.rdata    (rd_word),
		.offset   (tag_offset),
		.size     (tag_size),
		.sign_ext (tag_sign),
		.value    (extracted)
	);

endmodule

/* load_extract.sv */
`timescale 1ns/10ps

module load_extract (
	input  dmem_pkg::word_view_t           rdata,
	input  logic [1:0]                     offset,
	input  logic [1:0]                     size,
	input  logic                           sign_ext,
	output logic [dmem_pkg::WORD_BITS-1:0] value
);

	logic [dmem_pkg::LANE_BITS-1:0]   byte_sel;
	logic [2*dmem_pkg::LANE_BITS-1:0] half_sel;
	logic                             byte_fill;
	logic                             half_fill;

	// Addressed byte.
	assign byte_sel = rdata.lanes[offset];

	// Halfword lanes come from the pair picked by offset bit 1.
	assign half_sel = {rdata.lanes[{offset[1], 1'b1}], rdata.lanes[{offset[1], 1'b0}]};

	// Fill bits, zero unless sign extension is asked for.
	assign byte_fill = sign_ext & byte_sel[dmem_pkg::LANE_BITS-1];
	assign half_fill = sign_ext & half_sel[2*dmem_pkg::LANE_BITS-1];

	always_comb begin
		case (size)
			dmem_pkg::SIZE_BYTE: begin
				value = {{(dmem_pkg::WORD_BITS - dmem_pkg::LANE_BITS){byte_fill}}, byte_sel};
			end
			dmem_pkg::SIZE_HALF: begin
				value = {{(dmem_pkg::WORD_BITS - 2*dmem_pkg::LANE_BITS){half_fill}}, half_sel};
			end
			default: begin
				value = rdata.word;
			end
		endcase
	end

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module dmem_tb -f compile.f -o dmem_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dmem_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "FAIL: see errors above" "$log"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation passed"
exit 0

/* sdp_ram.sv */
`timescale 1ns/10ps

module sdp_ram (
	input  logic                                 clk,
	input  logic                                 en,
	input  logic [dmem_pkg::WORD_ADDR_BITS-1:0] waddr,
	input  logic [dmem_pkg::WORD_ADDR_BITS-1:0] raddr,
	input  logic [dmem_pkg::LANES-1:0]          strobe,
	input  dmem_pkg::word_view_t                wdata,
	output dmem_pkg::word_view_t                rdata
);

	dmem_pkg::word_view_t mem [2**dmem_pkg::WORD_ADDR_BITS];

	// Memory starts cleared in simulation.
	initial begin
		for (int i = 0; i < 2**dmem_pkg::WORD_ADDR_BITS; i++) begin
			mem[i] = '0;
		end
	end

	// Byte-strobed write port.
	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < dmem_pkg::LANES; i++) begin
				if (strobe[i]) begin
					mem[waddr].lanes[i] <= wdata.lanes[i];
				end
			end
		end
	end

	// Registered read.
	// A write to the same word in this cycle is not seen yet.
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

/* store_align.sv */
`timescale 1ns/10ps

module store_align (
	input  logic [1:0]                     size,
	input  logic [1:0]                     offset,
	input  logic [dmem_pkg::WORD_BITS-1:0] wdata,
	output logic [dmem_pkg::LANES-1:0]     strobe,
	output dmem_pkg::word_view_t           lanes
);

	// Lane mask from size and offset.
	always_comb begin
		strobe = '0;
		case (size)
			dmem_pkg::SIZE_BYTE: begin
				strobe[offset] = 1'b1;
			end
			dmem_pkg::SIZE_HALF: begin
				strobe[offset] = 1'b1;
				strobe[offset | 2'd1] = 1'b1;
			end
			dmem_pkg::SIZE_WORD: begin
				strobe = '1;
			end
			default: begin
				strobe = '0;
			end
		endcase
	end

	// Replicate the low byte or halfword so every candidate lane holds it.
	always_comb begin
		for (int i = 0; i < dmem_pkg::LANES; i++) begin
			case (size)
				dmem_pkg::SIZE_BYTE:
					lanes.lanes[i] = wdata[dmem_pkg::LANE_BITS-1:0];
				dmem_pkg::SIZE_HALF:
					lanes.lanes[i] = wdata[(i % 2) * dmem_pkg::LANE_BITS +: dmem_pkg::LANE_BITS];
				default:
					lanes.lanes[i] = wdata[i * dmem_pkg::LANE_BITS +: dmem_pkg::LANE_BITS];
			endcase
		end
	end

endmodule
